// ==== verilog/core_av_pkg.sv ====
//////////////////////////////////////////////////
// shared constants and types for the a/v core
// video timing, overlay geometry, colours and the
// i2s framing widths; referenced by scoped name
//////////////////////////////////////////////////

`default_nettype none

package core_av_pkg;

    //////////////////////////////////////////////////
    // vector types

    // counter or visible coordinate
    typedef logic [9:0] coord_t;
    // pixel, red in the high byte
    typedef logic [23:0] rgb_t;
    // status bits from the host side
    typedef logic [4:0] status_t;
    // one audio sample, two's complement
    typedef logic [15:0] sample_t;
    // mclk to sclk divider state
    typedef logic [1:0] sclk_div_t;
    // bit slot within one channel
    typedef logic [4:0] slot_t;

    //////////////////////////////////////////////////
    // video timing

    // line, in clocks
    localparam int h_total   = 400;
    localparam int h_bporch  = 10;
    localparam int h_active  = 320;
    // frame, in lines
    localparam int v_total   = 512;
    localparam int v_bporch  = 10;
    localparam int v_active  = 240;
    // hs fires a few clocks after vs, never on the same cycle
    localparam int hs_offset = 3;

    //////////////////////////////////////////////////
    // status overlay

    localparam int square_width  = 20;
    localparam int square_height = 20;
    localparam int square_count  = 5;

    // bit positions in status_t
    localparam int status_blue_bit  = 0;
    localparam int status_green_bit = 1;
    localparam int status_red_bit   = 2;
    localparam int status_blink_bit = 3;
    localparam int status_error_bit = 4;

    localparam rgb_t colour_red   = 24'hFF0000;
    localparam rgb_t colour_green = 24'h00FF00;
    localparam rgb_t colour_blue  = 24'h0000FF;
    localparam rgb_t colour_blink = 24'hFFFFFF;
    // dim yellow
    localparam rgb_t colour_error = 24'h7F7F00;
    localparam rgb_t colour_black = 24'h000000;

    //////////////////////////////////////////////////
    // i2s framing

    // data bits, then zero padding up to a full slot
    localparam int sample_bits = 16;
    localparam int slot_bits   = 32;

endpackage

`default_nettype wire

// ==== verilog/video_timing.sv ====
//////////////////////////////////////////////////
// raster timing for the 320x240 active window
// free running line and frame counters; sync,
// enable and visible coordinates are registered
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module video_timing (
    input  logic                 audgen_mclk,
    input  logic                 reset_n,
    output logic                 timing_de,
    output logic                 timing_hs,
    output logic                 timing_vs,
    output core_av_pkg::coord_t  pixel_x,
    output core_av_pkg::coord_t  pixel_y
);

    // raw position within line and frame
    core_av_pkg::coord_t x_count;
    core_av_pkg::coord_t y_count;

    logic line_end;
    logic frame_end;
    logic h_window;
    logic v_window;

    // last clock of a line / last line of a frame
    assign line_end  = (x_count == core_av_pkg::coord_t'(core_av_pkg::h_total - 1));
    assign frame_end = (y_count == core_av_pkg::coord_t'(core_av_pkg::v_total - 1));

    // active window, offset by the back porch
    assign h_window = (x_count >= core_av_pkg::coord_t'(core_av_pkg::h_bporch)) &&
                      (x_count <  core_av_pkg::coord_t'(core_av_pkg::h_bporch +
                                                        core_av_pkg::h_active));
    assign v_window = (y_count >= core_av_pkg::coord_t'(core_av_pkg::v_bporch)) &&
                      (y_count <  core_av_pkg::coord_t'(core_av_pkg::v_bporch +
                                                        core_av_pkg::v_active));

    //////////////////////////////////////////////////
    // counters

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_count <= '0;
            y_count <= '0;
        end else begin
            if (line_end) begin
                x_count <= '0;
                // step to next line, wrap at frame end
                if (frame_end) begin
                    y_count <= '0;
                end else begin
                    y_count <= y_count + 1'b1;
                end
            end else begin
                x_count <= x_count + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // decoded outputs, one clock behind the counters

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            timing_vs <= 1'b0;
            timing_hs <= 1'b0;
            timing_de <= 1'b0;
        end else begin
            // new frame
            timing_vs <= (x_count == '0) && (y_count == '0);
            // new line, a few clocks into the back porch
            timing_hs <= (x_count == core_av_pkg::coord_t'(core_av_pkg::hs_offset));
            timing_de <= h_window && v_window;
        end
    end

    // visible coordinates, only meaningful while de is high
    always_ff @(posedge audgen_mclk) begin
        pixel_x <= x_count - core_av_pkg::coord_t'(core_av_pkg::h_bporch);
        pixel_y <= y_count - core_av_pkg::coord_t'(core_av_pkg::v_bporch);
    end

endmodule

`default_nettype wire

// ==== verilog/status_overlay.sv ====
//////////////////////////////////////////////////
// paints five status squares at the top left of
// the active area; takes raster timing, returns
// the pixel with sync and enable kept aligned
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module status_overlay (
    input  logic                   audgen_mclk,
    input  logic                   reset_n,
    input  core_av_pkg::status_t   status,
    input  logic                   timing_de,
    input  logic                   timing_hs,
    input  logic                   timing_vs,
    input  core_av_pkg::coord_t    pixel_x,
    input  core_av_pkg::coord_t    pixel_y,
    output core_av_pkg::rgb_t      video_rgb,
    output logic                   video_de,
    output logic                   video_hs,
    output logic                   video_vs
);

    // resampled status, one stage
    core_av_pkg::status_t status_q;

    // square under the current pixel
    logic [2:0] square_sel;
    logic       square_hit;
    logic       square_on;

    core_av_pkg::rgb_t square_colour;
    core_av_pkg::rgb_t next_rgb;

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            status_q <= '0;
        end else begin
            status_q <= status;
        end
    end

    //////////////////////////////////////////////////
    // square select

    // first square spans x 0..20, the rest 20 wide each
    // scan from the right so the leftmost match wins
    always_comb begin
        square_hit = 1'b0;
        square_sel = '0;
        for (int k = core_av_pkg::square_count - 1; k >= 0; k--) begin
            if (pixel_x <= core_av_pkg::coord_t'(core_av_pkg::square_width * (k + 1))) begin
                square_hit = 1'b1;
                square_sel = 3'(k);
            end
        end
        // top rows only, y 0..20 inclusive
        if (pixel_y > core_av_pkg::coord_t'(core_av_pkg::square_height)) begin
            square_hit = 1'b0;
        end
    end

    // left to right: red, green, blue, blink, error
    always_comb begin
        case (square_sel)
            3'd0: begin
                square_on     = status_q[core_av_pkg::status_red_bit];
                square_colour = core_av_pkg::colour_red;
            end
            3'd1: begin
                square_on     = status_q[core_av_pkg::status_green_bit];
                square_colour = core_av_pkg::colour_green;
            end
            3'd2: begin
                square_on     = status_q[core_av_pkg::status_blue_bit];
                square_colour = core_av_pkg::colour_blue;
            end
            3'd3: begin
                square_on     = status_q[core_av_pkg::status_blink_bit];
                square_colour = core_av_pkg::colour_blink;
            end
            default: begin
                square_on     = status_q[core_av_pkg::status_error_bit];
                square_colour = core_av_pkg::colour_error;
            end
        endcase
    end

    // lit square colour, everything else black
    assign next_rgb = (timing_de && square_hit && square_on) ? square_colour
                                                             : core_av_pkg::colour_black;

    //////////////////////////////////////////////////
    // output stage

    // syncs delayed by the same stage as the pixel
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb <= core_av_pkg::colour_black;
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
        end else begin
            video_rgb <= next_rgb;
            video_de  <= timing_de;
            video_hs  <= timing_hs;
            video_vs  <= timing_vs;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/i2s_serializer.sv ====
//////////////////////////////////////////////////
// i2s transmitter, 16 data bits in 32-bit slots
// sclk is mclk/4, lrck low for the left channel;
// samples are taken at every left channel start
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module i2s_serializer (
    input  logic                   audgen_mclk,
    input  logic                   reset_n,
    input  core_av_pkg::sample_t   sample_left,
    input  core_av_pkg::sample_t   sample_right,
    output logic                   audio_sclk,
    output logic                   audio_lrck,
    output logic                   audio_dac
);

    core_av_pkg::sclk_div_t sclk_div;
    core_av_pkg::slot_t     slot_cnt;

    // right sample waits here during the left channel
    core_av_pkg::sample_t   right_hold;
    // msb goes out next
    core_av_pkg::sample_t   shift_q;

    logic sclk_fall;
    logic slot_last;

    //////////////////////////////////////////////////
    // bit clock

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            sclk_div <= '0;
        end else begin
            sclk_div <= sclk_div + 1'b1;
        end
    end

    // high bit of the divider, period of 4 mclk
    assign audio_sclk = sclk_div[1];

    // divider wraps 3 -> 0, sclk drops on this edge
    assign sclk_fall = (sclk_div == core_av_pkg::sclk_div_t'(2'd3));

    // leaving the final slot of a channel
    assign slot_last = (slot_cnt == core_av_pkg::slot_t'(core_av_pkg::slot_bits - 1));

    //////////////////////////////////////////////////
    // word clock

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            slot_cnt   <= '0;
            audio_lrck <= 1'b0;
        end else if (sclk_fall) begin
            // 32 slots per channel, wraps by width
            slot_cnt <= slot_cnt + 1'b1;
            if (slot_last) begin
                audio_lrck <= ~audio_lrck;
            end
        end
    end

    //////////////////////////////////////////////////
    // data shifter

    // first left channel after reset is silent
    // zeros shifted in fill slots 16..31
    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            audio_dac  <= 1'b0;
            shift_q    <= '0;
            right_hold <= '0;
        end else if (sclk_fall) begin
            if (slot_last && audio_lrck) begin
                // lrck falling, left channel starts
                right_hold <= sample_right;
                audio_dac  <= sample_left[core_av_pkg::sample_bits - 1];
                shift_q    <= {sample_left[core_av_pkg::sample_bits - 2:0], 1'b0};
            end else if (slot_last) begin
                // lrck rising, right channel starts
                audio_dac <= right_hold[core_av_pkg::sample_bits - 1];
                shift_q   <= {right_hold[core_av_pkg::sample_bits - 2:0], 1'b0};
            end else begin
                audio_dac <= shift_q[core_av_pkg::sample_bits - 1];
                shift_q   <= {shift_q[core_av_pkg::sample_bits - 2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/core_av_top.sv ====
//////////////////////////////////////////////////
// a/v core top level on the 12.288 mhz mclk
// video raster with status overlay, plus the
// i2s transmitter for the stereo samples
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module core_av_top (
    input  logic                   audgen_mclk,
    input  logic                   reset_n,
    input  core_av_pkg::status_t   status,
    input  core_av_pkg::sample_t   sample_left,
    input  core_av_pkg::sample_t   sample_right,
    output core_av_pkg::rgb_t      video_rgb,
    output logic                   video_de,
    output logic                   video_hs,
    output logic                   video_vs,
    output logic                   audio_sclk,
    output logic                   audio_lrck,
    output logic                   audio_dac
);

    //////////////////////////////////////////////////
    // video path

    // raster timing into the overlay
    logic                timing_de;
    logic                timing_hs;
    logic                timing_vs;
    core_av_pkg::coord_t pixel_x;
    core_av_pkg::coord_t pixel_y;

    video_timing u_video_timing (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .timing_de   (timing_de),
        .timing_hs   (timing_hs),
        .timing_vs   (timing_vs),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y)
    );

    // adds one more stage on top of the timing
    status_overlay u_status_overlay (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .status      (status),
        .timing_de   (timing_de),
        .timing_hs   (timing_hs),
        .timing_vs   (timing_vs),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_hs    (video_hs),
        .video_vs    (video_vs)
    );

    //////////////////////////////////////////////////
    // audio path

    // one stereo frame every 256 mclk
    i2s_serializer u_i2s_serializer (
        .audgen_mclk  (audgen_mclk),
        .reset_n      (reset_n),
        .sample_left  (sample_left),
        .sample_right (sample_right),
        .audio_sclk   (audio_sclk),
        .audio_lrck   (audio_lrck),
        .audio_dac    (audio_dac)
    );

endmodule

`default_nettype wire

// ==== tb/core_av_props.sv ====
//////////////////////////////////////////////////
// concurrent checks on sync pulses and i2s edges
// bound into the overlay and the serializer
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module core_av_props (
    input logic audgen_mclk,
    input logic reset_n,
    input logic hs,
    input logic vs,
    input logic sclk,
    input logic lrck,
    input logic dac
);

    // syncs are single clock pulses
    a_hs_pulse: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        hs |=> !hs)
        else $error("video_hs stayed high for more than one clock");

    a_vs_pulse: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        vs |=> !vs)
        else $error("video_vs stayed high for more than one clock");

    // first line sync of a frame, 3 clocks after vs
    a_vs_to_hs: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        vs |-> ##3 hs)
        else $error("video_hs did not follow video_vs after 3 clocks");

    // word clock and data move only with falling sclk
    a_lrck_edge: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $changed(lrck) |-> $fell(sclk))
        else $error("audio_lrck changed away from a falling audio_sclk");

    a_dac_edge: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $changed(dac) |-> $fell(sclk))
        else $error("audio_dac changed away from a falling audio_sclk");

endmodule

`default_nettype wire

// ==== tb/core_av_tb.sv ====
//////////////////////////////////////////////////
// testbench for the a/v core top level
// runs the raster over several frames with random
// status and samples and checks every output each clock
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module core_av_tb;

    logic                 audgen_mclk;
    logic                 reset_n;
    core_av_pkg::status_t status;
    core_av_pkg::sample_t sample_left;
    core_av_pkg::sample_t sample_right;
    core_av_pkg::rgb_t    video_rgb;
    logic                 video_de;
    logic                 video_hs;
    logic                 video_vs;
    logic                 audio_sclk;
    logic                 audio_lrck;
    logic                 audio_dac;

    int   seed;
    int   frame;
    int   stim_cycles;
    logic run_ok;

    // checker state
    int   cycle_n;
    int   check_count;
    int   error_count;
    core_av_pkg::status_t st_prev1;
    core_av_pkg::status_t st_prev2;
    core_av_pkg::sample_t prev_left;
    core_av_pkg::sample_t prev_right;
    core_av_pkg::sample_t lat_left;
    core_av_pkg::sample_t lat_right;
    logic [31:0] word;
    int   word_bits;
    logic last_sclk;
    logic last_lrck;
    logic last_de;
    int   de_run;
    int   de_lines;
    int   hs_count;
    logic frame_seen;

    core_av_top u_dut (
        .audgen_mclk  (audgen_mclk),
        .reset_n      (reset_n),
        .status       (status),
        .sample_left  (sample_left),
        .sample_right (sample_right),
        .video_rgb    (video_rgb),
        .video_de     (video_de),
        .video_hs     (video_hs),
        .video_vs     (video_vs),
        .audio_sclk   (audio_sclk),
        .audio_lrck   (audio_lrck),
        .audio_dac    (audio_dac)
    );

    // sync rules on the overlay with the audio inputs tied low
    bind status_overlay core_av_props u_overlay_props (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .hs          (video_hs),
        .vs          (video_vs),
        .sclk        (1'b0),
        .lrck        (1'b0),
        .dac         (1'b0)
    );

    // i2s edge rules with the sync inputs tied low
    bind i2s_serializer core_av_props u_i2s_props (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .hs          (1'b0),
        .vs          (1'b0),
        .sclk        (audio_sclk),
        .lrck        (audio_lrck),
        .dac         (audio_dac)
    );

    initial begin
        audgen_mclk = 1'b0;
        forever #20 audgen_mclk = ~audgen_mclk;
    end

    //////////////////////////////////////////////////
    // reference and compare

    // square j spans visible x in (20j, 20(j+1)] and square 0 also takes x=0
    function automatic core_av_pkg::rgb_t expected_pixel(input core_av_pkg::coord_t x,
                                                         input core_av_pkg::coord_t y,
                                                         input core_av_pkg::status_t st);
        int idx;
        if (y > core_av_pkg::coord_t'(core_av_pkg::square_height)) begin
            return core_av_pkg::colour_black;
        end
        idx = (x == 0) ? 0 : (int'(x) - 1) / core_av_pkg::square_width;
        case (idx)
            0: return st[core_av_pkg::status_red_bit]   ? core_av_pkg::colour_red
                                                        : core_av_pkg::colour_black;
            1: return st[core_av_pkg::status_green_bit] ? core_av_pkg::colour_green
                                                        : core_av_pkg::colour_black;
            2: return st[core_av_pkg::status_blue_bit]  ? core_av_pkg::colour_blue
                                                        : core_av_pkg::colour_black;
            3: return st[core_av_pkg::status_blink_bit] ? core_av_pkg::colour_blink
                                                        : core_av_pkg::colour_black;
            4: return st[core_av_pkg::status_error_bit] ? core_av_pkg::colour_error
                                                        : core_av_pkg::colour_black;
            default: return core_av_pkg::colour_black;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: expected %h, actual %h (cycle %0d)",
                     name, expected, actual, cycle_n);
        end
    endtask

    // n counts rising edges since reset release
    task automatic check_cycle(input int n);
        int c;
        int x;
        int y;
        logic exp_de;
        core_av_pkg::rgb_t exp_rgb;
        core_av_pkg::sample_t samp;
        // video sits two stages behind the raster counters
        x = -1;
        y = -1;
        c = -1;
        if (n >= 2) begin
            c = (n - 2) % (core_av_pkg::h_total * core_av_pkg::v_total);
            x = c % core_av_pkg::h_total;
            y = c / core_av_pkg::h_total;
        end
        exp_de = (x >= core_av_pkg::h_bporch) &&
                 (x < core_av_pkg::h_bporch + core_av_pkg::h_active) &&
                 (y >= core_av_pkg::v_bporch) &&
                 (y < core_av_pkg::v_bporch + core_av_pkg::v_active);
        exp_rgb = core_av_pkg::colour_black;
        if (exp_de) begin
            exp_rgb = expected_pixel(core_av_pkg::coord_t'(x - core_av_pkg::h_bporch),
                                     core_av_pkg::coord_t'(y - core_av_pkg::v_bporch),
                                     st_prev2);
        end
        check_value("video_vs", c == 0, video_vs);
        check_value("video_hs", x == core_av_pkg::hs_offset, video_hs);
        check_value("video_de", exp_de, video_de);
        check_value("video_rgb", exp_rgb, video_rgb);

        // line and frame totals from the observed pulses
        if (video_de) begin
            de_run++;
        end else if (last_de) begin
            check_value("pixels per line", core_av_pkg::h_active, de_run);
            de_lines++;
            de_run = 0;
        end
        if (video_hs) begin
            hs_count++;
        end
        if (video_vs) begin
            if (frame_seen) begin
                check_value("lines per frame", core_av_pkg::v_total, hs_count);
                check_value("active lines per frame", core_av_pkg::v_active, de_lines);
            end
            hs_count   = 0;
            de_lines   = 0;
            frame_seen = 1'b1;
        end
        last_de = video_de;

        // sclk is mclk/4 and one channel lasts 32 sclk periods
        if (n > 0 && n % (8 * core_av_pkg::slot_bits) == 0) begin
            lat_left  = prev_left;
            lat_right = prev_right;
        end
        check_value("audio_sclk", (n % 4) >= 2, audio_sclk);
        check_value("audio_lrck", (n / (4 * core_av_pkg::slot_bits)) % 2, audio_lrck);

        // rebuild each channel word from the rising sclk samples
        if (audio_lrck !== last_lrck) begin
            word      = '0;
            word_bits = 0;
        end
        if (audio_sclk && !last_sclk) begin
            word = {word[30:0], audio_dac};
            word_bits++;
            if (word_bits == core_av_pkg::slot_bits) begin
                samp = audio_lrck ? lat_right : lat_left;
                if (audio_lrck) begin
                    check_value("i2s right word", {samp, 16'h0000}, word);
                end else begin
                    check_value("i2s left word", {samp, 16'h0000}, word);
                end
                word_bits = 0;
            end
        end
        last_lrck = audio_lrck;
        last_sclk = audio_sclk;
    endtask

    always @(negedge audgen_mclk) begin
        if (!reset_n) begin
            check_value("reset video_rgb", '0, video_rgb);
            check_value("reset video_de", '0, video_de);
            check_value("reset video_hs", '0, video_hs);
            check_value("reset video_vs", '0, video_vs);
            check_value("reset audio_sclk", '0, audio_sclk);
            check_value("reset audio_lrck", '0, audio_lrck);
            check_value("reset audio_dac", '0, audio_dac);
        end else begin
            check_cycle(cycle_n);
            cycle_n++;
        end
        // inputs as seen here are what the next edge samples
        st_prev2   = st_prev1;
        st_prev1   = status;
        prev_left  = sample_left;
        prev_right = sample_right;
    end

    //////////////////////////////////////////////////
    // stimulus

    // steps the clock and draws new samples every 999 cycles
    // so the sample updates drift across the lrck phase
    task automatic wait_frame_start(output logic found);
        int waited;
        found  = 1'b0;
        waited = 0;
        while (!found && waited < core_av_pkg::h_total * core_av_pkg::v_total + 16) begin
            @(posedge audgen_mclk);
            #2;
            waited++;
            stim_cycles++;
            if (stim_cycles % 999 == 0) begin
                sample_left  = core_av_pkg::sample_t'($random(seed));
                sample_right = core_av_pkg::sample_t'($random(seed));
            end
            if (video_vs) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("timeout: video_vs did not pulse within one frame time");
            error_count++;
        end
    endtask

    task automatic report_results();
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
    endtask

    initial begin
        seed         = 65388;
        reset_n      = 1'b0;
        status       = '0;
        sample_left  = '0;
        sample_right = '0;
        run_ok       = 1'b1;
        stim_cycles  = 0;
        cycle_n      = 0;
        check_count  = 0;
        error_count  = 0;
        st_prev1     = '0;
        st_prev2     = '0;
        prev_left    = '0;
        prev_right   = '0;
        lat_left     = '0;
        lat_right    = '0;
        word         = '0;
        word_bits    = 0;
        last_sclk    = 1'b0;
        last_lrck    = 1'b0;
        last_de      = 1'b0;
        de_run       = 0;
        de_lines     = 0;
        hs_count     = 0;
        frame_seen   = 1'b0;

        repeat (10) @(posedge audgen_mclk);
        #2;
        reset_n = 1'b1;

        // new status at each frame start while in vertical blanking
        for (frame = 0; frame < 3 && run_ok; frame++) begin
            wait_frame_start(run_ok);
            if (run_ok) begin
                status = core_av_pkg::status_t'($random(seed));
            end
        end
        if (run_ok) begin
            repeat (16) @(posedge audgen_mclk);
        end
        report_results();
        $finish;
    end

endmodule

`default_nettype wire

// ==== core_av_top.f ====
verilog/core_av_pkg.sv
verilog/video_timing.sv
verilog/status_overlay.sv
verilog/i2s_serializer.sv
verilog/core_av_top.sv
tb/core_av_props.sv
tb/core_av_tb.sv

// ==== Bender.yml ====
package:
  name: core_av

sources:
  - verilog/core_av_pkg.sv
  - verilog/video_timing.sv
  - verilog/status_overlay.sv
  - verilog/i2s_serializer.sv
  - verilog/core_av_top.sv
  - target: simulation
    files:
      - tb/core_av_props.sv
      - tb/core_av_tb.sv
